//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= routerTb
FILELIST  ?= all.f
OBJDIR    ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJDIR)

//--- all.f
+incdir+verilog
verilog/nocPkg.sv
verilog/grantTimer.sv
verilog/portArbiter.sv
verilog/inputPort.sv
verilog/outputStage.sv
verilog/routerOutput.sv
dv/routerTbChecks.sv
dv/routerTb.sv

//--- dv/routerTb.sv
`timescale 1ns/1ps

module routerTb
  import nocPkg::*;
();

  localparam int TOTAL_FLITS = 5 * 2 + 5 * 3 * 4 + 6;
  localparam int CYCLE_LIMIT = 40 * TOTAL_FLITS + 200;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  portMask_t   inReq = '0;
  portMask_t   inAck;
  flit_t       inFlit [5] = '{default: '0};
  logic        outReq;
  logic        outAck = 1'b0;
  flit_t       outFlit;
  portIdx_t    outSrc;
  int          phase = 0;
  int          mismatches, failures, pending;
  int          endFails = 0;
  int          cycles = 0;
  int          gapCnt [5] = '{default: 0};
  logic [1:0]  ackDelay = '0;
  logic [31:0] lfsr = 32'h611d0df6;
  logic [31:0] sendQ [5][$];   // {gap cycles, flit}.

  always #4 clk = ~clk;

  routerOutput routerOutput_inst (.clk(clk), .rst(rst), .inReq(inReq), .inAck(inAck),
    .inFlitL(inFlit[0]), .inFlitN(inFlit[1]), .inFlitE(inFlit[2]), .inFlitW(inFlit[3]),
    .inFlitS(inFlit[4]), .outReq(outReq), .outAck(outAck), .outFlit(outFlit), .outSrc(outSrc));

  routerTbChecks checks (.clk(clk), .rst(rst), .inReq(inReq), .inAck(inAck),
    .inFlitL(inFlit[0]), .inFlitN(inFlit[1]), .inFlitE(inFlit[2]), .inFlitW(inFlit[3]),
    .inFlitS(inFlit[4]), .outReq(outReq), .outAck(outAck), .outFlit(outFlit),
    .outSrc(outSrc), .phase(phase), .mismatches(mismatches), .failures(failures),
    .pending(pending));

  // fibonacci lfsr, taps 32 22 2 1, one step per bit.
  function automatic logic [3:0] randBits(int n);
    logic [3:0] v;
    logic       fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[2:0], fb};
    end
    return v;
  endfunction

  task automatic queueFlit(int p, int gap, flitId_t id, int tag);
    flit_t f;
    f = {id, 1'b0, 12'(tag)};
    sendQ[p].push_back({16'(gap), f});
  endtask

  task automatic waitQuiet();
    int idleRun;
    int left;
    idleRun = 0;
    while (idleRun < 5)
    begin
      @(posedge clk);
      left = 0;
      for (int p = 0; p < 5; p++)
        left += sendQ[p].size();
      if (left == 0 && inReq == '0 && inAck == '0 && !outReq && !outAck)
        idleRun++;
      else
        idleRun = 0;
    end
  endtask

  // upstream four-phase drivers.
  always @(posedge clk)
  begin
    logic [31:0] entry;
    if (!rst)
      for (int p = 0; p < 5; p++)
        if (inReq[p])
        begin
          if (inAck[p])
            inReq[p] <= 1'b0;
        end
        else if (!inAck[p] && sendQ[p].size() > 0)
        begin
          if (gapCnt[p] < int'(sendQ[p][0][31:16]))
            gapCnt[p] <= gapCnt[p] + 1;
          else
          begin
            entry = sendQ[p].pop_front();
            inFlit[p] <= entry[15:0];
            inReq[p]  <= 1'b1;
            gapCnt[p] <= 0;
          end
        end
  end

  // downstream responder with a random ack delay.
  always @(posedge clk)
  begin
    if (rst)
      outAck <= 1'b0;
    else if (outReq && !outAck)
    begin
      if (ackDelay == 2'd0)
        outAck <= 1'b1;
      else
        ackDelay <= ackDelay - 2'd1;
    end
    else if (!outReq && outAck)
    begin
      outAck   <= 1'b0;
      ackDelay <= 2'(randBits(2));
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT)
    begin
      $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial
  begin
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    waitQuiet();

    // all heads on one edge after idle.
    @(negedge clk);
    phase = 1;
    for (int p = 0; p < 5; p++)
    begin
      queueFlit(p, 0, FLIT_HEAD, 4095);
      queueFlit(p, 0, FLIT_TAIL, (p << 8) | 1);
    end
    waitQuiet();

    // long budgets, so packets stay whole.
    @(negedge clk);
    phase = 2;
    for (int k = 0; k < 3; k++)
      for (int p = 0; p < 5; p++)
      begin
        queueFlit(p, randBits(2), FLIT_HEAD, 4095);
        queueFlit(p, randBits(2), FLIT_BODY, (p << 8) | (k << 4) | 1);
        queueFlit(p, randBits(2), FLIT_BODY, (p << 8) | (k << 4) | 2);
        queueFlit(p, randBits(2), FLIT_TAIL, (p << 8) | (k << 4) | 3);
      end
    waitQuiet();

    // L stalls mid packet with a short budget.
    @(negedge clk);
    phase = 3;
    queueFlit(0, 0, FLIT_HEAD, 3);
    queueFlit(0, 20, FLIT_BODY, 12'h0a1);
    queueFlit(0, 0, FLIT_TAIL, 12'h0a2);
    queueFlit(1, 1, FLIT_HEAD, 4095);
    queueFlit(1, 0, FLIT_BODY, 12'h1b1);
    queueFlit(1, 0, FLIT_TAIL, 12'h1b2);
    waitQuiet();

    if (pending != 0)
    begin
      endFails++;
      $display("%0d sent flits never reached the output", pending);
    end
    $display("errors: mismatches %0d, other failures %0d", mismatches, failures + endFails);
    if (mismatches == 0 && failures == 0 && endFails == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- dv/routerTbChecks.sv
`timescale 1ns/1ps

module routerTbChecks
  import nocPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  portMask_t inReq,
  input  portMask_t inAck,
  input  flit_t     inFlitL,
  input  flit_t     inFlitN,
  input  flit_t     inFlitE,
  input  flit_t     inFlitW,
  input  flit_t     inFlitS,
  input  logic      outReq,
  input  logic      outAck,
  input  flit_t     outFlit,
  input  portIdx_t  outSrc,
  input  int        phase,      // 1 idle priority, 2 contiguity, 3 timeout release.
  output int        mismatches,
  output int        failures,
  output int        pending
);

  flit_t     expQ [5][$];
  portMask_t reqSeen = '0;
  logic      accepted = 1'b0;
  logic      firstDone = 1'b0;
  logic      ownerValid = 1'b0;
  portIdx_t  owner = '0;
  logic      sawN = 1'b0;
  int        scoreFails = 0;
  int        resetFails = 0;
  int        ackFails = 0;
  int        reqFails = 0;
  int        holdFails = 0;

  initial mismatches = 0;
  initial pending = 0;

  assign failures = scoreFails + resetFails + ackFails + reqFails + holdFails;

  function automatic flit_t flitOf(int p);
    case (p)
      1: return inFlitN;
      2: return inFlitE;
      3: return inFlitW;
      4: return inFlitS;
      default: return inFlitL;
    endcase
  endfunction

  function automatic string testName(int ph);
    case (ph)
      1: return "idlePriority";
      2: return "packetContiguity";
      3: return "timeoutRelease";
      default: return "dataIntegrity";
    endcase
  endfunction

  task automatic scoreFlit(portIdx_t src, flit_t f);
    flit_t exp;
    if (src > 3'd4 || expQ[src].size() == 0)
    begin
      scoreFails++;
      $display("flit %h arrived from port %0d, which had nothing outstanding", f, src);
      return;
    end
    exp = expQ[src].pop_front();
    pending--;
    if (exp != f)
    begin
      mismatches++;
      $display("mismatch %s port %0d expected %h actual %h", testName(phase), src, exp, f);
    end
    if (phase == 1 && !firstDone)
    begin
      firstDone = 1'b1;
      if (src != 3'd0)
      begin
        mismatches++;
        $display("mismatch %s expected 0 actual %0d", testName(phase), src);
      end
    end
    if ((phase == 1 || phase == 2) && ownerValid && src != owner)
    begin
      mismatches++;
      $display("mismatch %s expected %0d actual %0d", testName(phase), owner, src);
    end
    if (f[15:13] == FLIT_HEAD)
    begin
      ownerValid = 1'b1;
      owner      = src;
    end
    else if (f[15:13] == FLIT_TAIL)
      ownerValid = 1'b0;
    if (phase == 3 && src == 3'd1)
      sawN = 1'b1;
    if (phase == 3 && src == 3'd0 && f[15:13] == FLIT_TAIL && !sawN)
    begin
      scoreFails++;
      $display("port L finished its packet before port N got the output; grant did not expire");
    end
  endtask

  // record each flit as its request rises and check it when the output acks.
  always @(posedge clk)
  begin
    if (!rst)
    begin
      for (int p = 0; p < 5; p++)
        if (inReq[p] && !reqSeen[p])
        begin
          expQ[p].push_back(flitOf(p));
          pending++;
        end
      reqSeen = inReq;
      if (!outReq)
        accepted = 1'b0;
      else if (outAck && !accepted)
      begin
        accepted = 1'b1;
        scoreFlit(outSrc, outFlit);
      end
    end
  end

  // ######################################################################
  // handshake rules
  // ######################################################################

  resetQuiet: assert property (@(posedge clk) rst |=> !outReq && inAck == '0)
    else begin resetFails++; $display("outReq or inAck was high during or right after reset"); end

  ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
    (inAck & ~$past(inAck) & ~inReq) == '0)
    else begin ackFails++; $display("inAck rose while inReq was low"); end

  reqHeld: assert property (@(posedge clk) disable iff (rst) $fell(outReq) |-> $past(outAck))
    else begin reqFails++; $display("outReq dropped before outAck was seen"); end

  dataHeld: assert property (@(posedge clk) disable iff (rst)
    outReq && !outAck |=> $stable(outFlit) && $stable(outSrc))
    else begin holdFails++; $display("outFlit or outSrc changed while waiting for outAck"); end

endmodule

//--- verilog/grantTimer.sv
`timescale 1ns/1ps

module grantTimer
  import nocPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  flitId_t flitId,
  input  pktLen_t length,
  input  logic    runTimer,
  output logic    timesUp
);

  pktLen_t budget;
  pktLen_t count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budget <= '0;
      count  <= '0;
    end
    else
    begin
      if (flitId == FLIT_HEAD)
        budget <= length;        // reload on every head seen.
      if (runTimer)
        count <= count + 1'b1;
      else
        count <= '0;             // restart when the grant is not held.
    end
  end

  assign timesUp = (count == budget);

endmodule

//--- verilog/inputPort.sv
`timescale 1ns/1ps

module inputPort
  import nocPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    inReq,
  input  flit_t   inFlit,
  output logic    inAck,
  input  logic    take,
  output logic    hasFlit,
  output logic    busy,
  output flit_t   curFlit,
  output flitId_t curId,
  output pktLen_t curLen
);

  flit_t flitReg;
  logic  inPacket;
  logic  capture;

  // new request, slot empty and previous handshake closed.
  assign capture = inReq && !hasFlit && !inAck;

  always_ff @(posedge clk)
  begin
    if (capture)
      flitReg <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      hasFlit  <= 1'b0;
      inAck    <= 1'b0;
      inPacket <= 1'b0;
    end
    else
    begin
      if (take)
      begin
        hasFlit <= 1'b0;
        inAck   <= 1'b1;               // flit is gone, release the sender.
        if (curId == FLIT_HEAD)
          inPacket <= 1'b1;
        else if (curId == FLIT_TAIL)
          inPacket <= 1'b0;
      end
      else if (capture)
        hasFlit <= 1'b1;
      if (inAck && !inReq)
        inAck <= 1'b0;
    end
  end

  assign busy    = hasFlit | inPacket;
  assign curFlit = flitReg;
  assign curId   = hasFlit ? flitReg[15:13] : '0; // id only while a flit is held.
  assign curLen  = flitReg[11:0];

  takeNeedsFlit: assert property (@(posedge clk) disable iff (rst) take |-> hasFlit);

endmodule

//--- verilog/nocCfg.svh
`ifndef NOC_CFG_SVH
`define NOC_CFG_SVH

// router geometry.
`define NOC_PORTS 5

// flit layout.
`define FLIT_WIDTH 16

// head flit payload holds the grant budget in cycles.
`define LEN_WIDTH 12

`endif

//--- verilog/nocPkg.sv
`include "nocCfg.svh"

package nocPkg;

  typedef logic [`FLIT_WIDTH-1:0] flit_t;   // [15:13] id, [12] spare, [11:0] payload.
  typedef logic [2:0]             flitId_t;
  typedef logic [`LEN_WIDTH-1:0]  pktLen_t;
  typedef logic [`NOC_PORTS-1:0]  portMask_t; // bit 0 is L, then N, E, W, S.
  typedef logic [2:0]             portIdx_t;

  localparam flitId_t FLIT_HEAD = 3'b001;
  localparam flitId_t FLIT_BODY = 3'b010;
  localparam flitId_t FLIT_TAIL = 3'b011;

  // one-hot grant states.
  typedef enum logic [5:0] {
    ARB_IDLE = 6'b000001,
    ARB_L    = 6'b000010,
    ARB_N    = 6'b000100,
    ARB_E    = 6'b001000,
    ARB_W    = 6'b010000,
    ARB_S    = 6'b100000
  } arbState_e;

endpackage

//--- verilog/outputStage.sv
`timescale 1ns/1ps

module outputStage
  import nocPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  portMask_t grant,
  input  portMask_t hasFlit,
  input  flit_t     flitL,
  input  flit_t     flitN,
  input  flit_t     flitE,
  input  flit_t     flitW,
  input  flit_t     flitS,
  output portMask_t take,
  output logic      outReq,
  input  logic      outAck,
  output flit_t     outFlit,
  output portIdx_t  outSrc
);

  typedef enum logic {OS_IDLE, OS_SEND} osState_e;

  osState_e  state;
  portMask_t sel;
  portIdx_t  selIdx;
  flit_t     selFlit;
  logic      load;

  assign sel  = grant & hasFlit;
  assign load = (state == OS_IDLE) && (|sel);

  always_comb
  begin
    case (sel)
      5'b00010: begin selIdx = 3'd1; selFlit = flitN; end
      5'b00100: begin selIdx = 3'd2; selFlit = flitE; end
      5'b01000: begin selIdx = 3'd3; selFlit = flitW; end
      5'b10000: begin selIdx = 3'd4; selFlit = flitS; end
      default:  begin selIdx = 3'd0; selFlit = flitL; end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      outFlit <= selFlit;
      outSrc  <= selIdx;             // source tag for interleaved packets.
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state  <= OS_IDLE;
      outReq <= 1'b0;
      take   <= '0;
    end
    else
    begin
      take <= load ? sel : '0;       // single-cycle pulse.
      case (state)
        OS_IDLE:
          if (load)
          begin
            state  <= OS_SEND;
            outReq <= 1'b1;
          end
        default:
          if (outReq && outAck)
            outReq <= 1'b0;
          else if (!outReq && !outAck)
            state <= OS_IDLE;          // four-phase cycle closed.
      endcase
    end
  end

  outHold: assert property (@(posedge clk) disable iff (rst)
    outReq && !outAck |=> $stable(outFlit) && $stable(outSrc));

endmodule

//--- verilog/portArbiter.sv
`timescale 1ns/1ps
`include "nocCfg.svh"

module portArbiter
  import nocPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  portMask_t busy,
  input  flitId_t   curIdL,
  input  flitId_t   curIdN,
  input  flitId_t   curIdE,
  input  flitId_t   curIdW,
  input  flitId_t   curIdS,
  input  pktLen_t   curLenL,
  input  pktLen_t   curLenN,
  input  pktLen_t   curLenE,
  input  pktLen_t   curLenW,
  input  pktLen_t   curLenS,
  output portMask_t grant
);

  arbState_e state;
  arbState_e nextState;
  portMask_t runTimer;
  portMask_t timesUp;
  portMask_t holdPort;
  portIdx_t  curIdx;
  portIdx_t  startIdx;

  // first requesting port at or after start, wrapping around.
  function automatic arbState_e firstBusy(portMask_t req, portIdx_t start);
    int        idx;
    arbState_e pick;
    pick = ARB_IDLE;
    for (int k = `NOC_PORTS - 1; k >= 0; k--)
    begin
      idx = (int'(start) + k) % `NOC_PORTS;
      if (req[idx])
        pick = arbState_e'(6'b000010 << idx); // lowest k wins.
    end
    return pick;
  endfunction

  // ####################################################################
  // per-port grant timers
  // ####################################################################

  grantTimer timerL (.clk(clk), .rst(rst), .flitId(curIdL), .length(curLenL),
                     .runTimer(runTimer[0]), .timesUp(timesUp[0]));
  grantTimer timerN (.clk(clk), .rst(rst), .flitId(curIdN), .length(curLenN),
                     .runTimer(runTimer[1]), .timesUp(timesUp[1]));
  grantTimer timerE (.clk(clk), .rst(rst), .flitId(curIdE), .length(curLenE),
                     .runTimer(runTimer[2]), .timesUp(timesUp[2]));
  grantTimer timerW (.clk(clk), .rst(rst), .flitId(curIdW), .length(curLenW),
                     .runTimer(runTimer[3]), .timesUp(timesUp[3]));
  grantTimer timerS (.clk(clk), .rst(rst), .flitId(curIdS), .length(curLenS),
                     .runTimer(runTimer[4]), .timesUp(timesUp[4]));

  // ####################################################################
  // grant state machine
  // ####################################################################

  assign grant    = state[5:1];
  assign holdPort = grant & busy & ~timesUp;
  assign runTimer = holdPort;           // only the holder counts.

  always_comb
  begin
    case (state)
      ARB_N:   curIdx = 3'd1;
      ARB_E:   curIdx = 3'd2;
      ARB_W:   curIdx = 3'd3;
      ARB_S:   curIdx = 3'd4;
      default: curIdx = 3'd0;
    endcase
  end

  always_comb
  begin
    if (state == ARB_IDLE)
      startIdx = 3'd0;                  // fixed order L, N, E, W, S.
    else if (curIdx == portIdx_t'(`NOC_PORTS - 1))
      startIdx = 3'd0;
    else
      startIdx = curIdx + 3'd1;         // current port comes last.
  end

  always_comb
  begin
    if (|holdPort)
      nextState = state;
    else
      nextState = firstBusy(busy, startIdx);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= ARB_IDLE;
    else
      state <= nextState;
  end

  stateLegal: assert property (@(posedge clk) disable iff (rst)
    state inside {ARB_IDLE, ARB_L, ARB_N, ARB_E, ARB_W, ARB_S});

  grantOneHot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant));

endmodule

//--- verilog/routerOutput.sv
`timescale 1ns/1ps

module routerOutput
  import nocPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  portMask_t inReq,
  output portMask_t inAck,
  input  flit_t     inFlitL,
  input  flit_t     inFlitN,
  input  flit_t     inFlitE,
  input  flit_t     inFlitW,
  input  flit_t     inFlitS,
  output logic      outReq,
  input  logic      outAck,
  output flit_t     outFlit,
  output portIdx_t  outSrc
);

  portMask_t hasFlit;
  portMask_t busy;
  portMask_t take;
  portMask_t grant;
  flit_t     flitL, flitN, flitE, flitW, flitS;
  flitId_t   idL, idN, idE, idW, idS;
  pktLen_t   lenL, lenN, lenE, lenW, lenS;

  // ####################################################################
  // input ports
  // ####################################################################

  inputPort portL (.clk(clk), .rst(rst), .inReq(inReq[0]), .inFlit(inFlitL),
                   .inAck(inAck[0]), .take(take[0]), .hasFlit(hasFlit[0]),
                   .busy(busy[0]), .curFlit(flitL), .curId(idL), .curLen(lenL));
  inputPort portN (.clk(clk), .rst(rst), .inReq(inReq[1]), .inFlit(inFlitN),
                   .inAck(inAck[1]), .take(take[1]), .hasFlit(hasFlit[1]),
                   .busy(busy[1]), .curFlit(flitN), .curId(idN), .curLen(lenN));
  inputPort portE (.clk(clk), .rst(rst), .inReq(inReq[2]), .inFlit(inFlitE),
                   .inAck(inAck[2]), .take(take[2]), .hasFlit(hasFlit[2]),
                   .busy(busy[2]), .curFlit(flitE), .curId(idE), .curLen(lenE));
  inputPort portW (.clk(clk), .rst(rst), .inReq(inReq[3]), .inFlit(inFlitW),
                   .inAck(inAck[3]), .take(take[3]), .hasFlit(hasFlit[3]),
                   .busy(busy[3]), .curFlit(flitW), .curId(idW), .curLen(lenW));
  inputPort portS (.clk(clk), .rst(rst), .inReq(inReq[4]), .inFlit(inFlitS),
                   .inAck(inAck[4]), .take(take[4]), .hasFlit(hasFlit[4]),
                   .busy(busy[4]), .curFlit(flitS), .curId(idS), .curLen(lenS));

  // ####################################################################
  // arbitration and output
  // ####################################################################

  portArbiter arbiter (.clk(clk), .rst(rst), .busy(busy),
                       .curIdL(idL), .curIdN(idN), .curIdE(idE), .curIdW(idW),
                       .curIdS(idS), .curLenL(lenL), .curLenN(lenN), .curLenE(lenE),
                       .curLenW(lenW), .curLenS(lenS), .grant(grant));

  outputStage sender (.clk(clk), .rst(rst), .grant(grant), .hasFlit(hasFlit),
                      .flitL(flitL), .flitN(flitN), .flitE(flitE), .flitW(flitW),
                      .flitS(flitS), .take(take), .outReq(outReq), .outAck(outAck),
                      .outFlit(outFlit), .outSrc(outSrc));

endmodule
